/* verification/lcd_stimulus.txt */
// per line: mode, then 32 expected ASCII hex bytes (positions 0..15 line one, 16..31 line two)
// the testbench adds the 0x80 and 0xC0 address instructions itself
00 20 20 20 49 6E 69 74 69 61 6C 69 7A 69 6E 67 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20
04 20 20 20 50 6C 61 79 69 6E 67 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20
01 20 20 20 53 74 6F 70 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20
07 20 20 20 52 65 63 6F 72 64 69 6E 67 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 // mode 7 shows the recording screen of mode 5
02 20 20 20 50 6C 61 79 20 50 61 75 73 65 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20
03 20 20 20 52 65 63 6F 72 64 20 50 61 75 73 65 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20

/* verilog.f */
src/lcd_pkg.sv
src/lcd_xfer_if.sv
src/lcd_bus_driver.sv
src/lcd_message_rom.sv
src/lcd_display_ctrl.sv
src/lcd_top.sv
verification/lcd_top_sva.sv
verification/tb_lcd_top.sv

/* run_sim.sh */
#!/bin/bash
# compile and run the LCD testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --assert --top-module tb_lcd_top -f verilog.f -o sim_lcd > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    echo "Verilator compile failed, see $BUILD_LOG"
    exit 1
fi

./obj_dir/sim_lcd > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Test failed" "$SIM_LOG"; then
    echo "FAIL"
    exit 1
fi

echo "PASS"
exit 0

/* verification/tb_lcd_top.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_lcd_top;

    localparam int NUM_RENDERS    = 6;
    localparam int LINE_WORDS     = 33;     // mode byte then 32 characters
    localparam int INIT_TIMEOUT   = 200;
    localparam int RENDER_TIMEOUT = 1000;

    logic       i_clk;
    logic       i_rst_n;
    logic       i_start;
    logic [2:0] i_mode;
    logic [7:0] o_lcd_data;
    logic       o_lcd_en;
    logic       o_lcd_rs;
    logic       o_init_finish;
    logic       o_render_finish;

    logic [7:0] stim_mem [NUM_RENDERS * LINE_WORDS];
    logic [8:0] capture_q [$];  // {rs, data} per en pulse
    logic [8:0] expect_q [$];
    int         error_count;
    integer     seed;

    lcd_top lcd_top_i (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_start         (i_start),
        .i_mode          (i_mode),
        .o_lcd_data      (o_lcd_data),
        .o_lcd_en        (o_lcd_en),
        .o_lcd_rs        (o_lcd_rs),
        .o_init_finish   (o_init_finish),
        .o_render_finish (o_render_finish)
    );

    always #50 i_clk = ~i_clk;

    // the LCD latches on the falling edge of en
    always @(negedge o_lcd_en) begin
        capture_q.push_back({o_lcd_rs, o_lcd_data});
    end

    task automatic wait_for_flag(input bit render, input int limit);
        int n;
        bit ok;
        n  = 0;
        ok = 1'b0;
        while (!ok && n < limit) begin
            @(posedge i_clk);
            #1;
            ok = render ? o_render_finish : o_init_finish;
            n++;
        end
        if (!ok) begin
            $display("Timeout: %s did not rise within %0d cycles",
                     render ? "o_render_finish" : "o_init_finish", limit);
            error_count++;
        end
    endtask

    task automatic collect_transfers(input int count, input int limit);
        int n;
        n = 0;
        while (capture_q.size() < count && n < limit) begin
            @(posedge i_clk);
            #1;
            n++;
        end
        if (capture_q.size() < count) begin
            $display("Timeout: only %0d of %0d LCD transfers seen within %0d cycles",
                     capture_q.size(), count, limit);
            error_count++;
        end
    endtask

    task automatic compare_transfers(input string label);
        int i;
        if (capture_q.size() != expect_q.size()) begin
            $display("Error at %0t: %s saw %0d transfers, expected %0d",
                     $time, label, capture_q.size(), expect_q.size());
            error_count++;
        end
        for (i = 0; i < expect_q.size() && i < capture_q.size(); i++) begin
            if (capture_q[i] !== expect_q[i]) begin
                $display("Error at %0t: %s transfer %0d is %0b/%02h, expected %0b/%02h",
                         $time, label, i, capture_q[i][8], capture_q[i][7:0],
                         expect_q[i][8], expect_q[i][7:0]);
                error_count++;
            end
        end
        capture_q.delete();
    endtask

    initial begin
        int         r;
        int         i;
        int         gap;
        int         base;
        logic [2:0] mode;

        i_clk       = 1'b0;
        i_rst_n     = 1'b1;
        i_start     = 1'b0;
        i_mode      = 3'd0;
        error_count = 0;
        seed        = 32'hd5fc;
        $readmemh("verification/lcd_stimulus.txt", stim_mem);

        repeat (5) @(posedge i_clk);
        #1;
        i_rst_n = 1'b0;
        capture_q.delete();

        // power-up instructions
        wait_for_flag(1'b0, INIT_TIMEOUT);
        expect_q.delete();
        expect_q.push_back(9'h038);
        expect_q.push_back(9'h008);
        expect_q.push_back(9'h001);
        expect_q.push_back(9'h006);
        expect_q.push_back(9'h00C);
        compare_transfers("init");
        if (o_render_finish !== 1'b0) begin
            $display("Error at %0t: o_render_finish is 1 before any render", $time);
            error_count++;
        end

        for (r = 0; r < NUM_RENDERS; r++) begin
            base = r * LINE_WORDS;
            mode = stim_mem[base][2:0];
            gap  = $unsigned($random(seed)) % 8;

            for (i = 0; i < gap; i++) begin
                @(posedge i_clk);
                #1;
                if (r > 0 && o_render_finish !== 1'b1) begin
                    $display("Error at %0t: o_render_finish dropped in idle gap", $time);
                    error_count++;
                end
            end
            if (capture_q.size() != 0) begin
                $display("Error at %0t: %0d extra transfers after render finish",
                         $time, capture_q.size());
                error_count++;
                capture_q.delete();
            end

            expect_q.delete();
            expect_q.push_back(9'h080);
            for (i = 0; i < 16; i++) begin
                expect_q.push_back({1'b1, stim_mem[base + 1 + i]});
            end
            expect_q.push_back(9'h0C0);
            for (i = 16; i < 32; i++) begin
                expect_q.push_back({1'b1, stim_mem[base + 1 + i]});
            end

            i_start = 1'b1;
            i_mode  = mode;
            @(posedge i_clk);
            #1;
            i_start = 1'b0;
            if (o_render_finish !== 1'b0) begin
                $display("Error at %0t: o_render_finish still 1 after start, mode %0d",
                         $time, mode);
                error_count++;
            end

            // start with another mode mid-render is ignored
            collect_transfers(10, RENDER_TIMEOUT);
            i_start = 1'b1;
            i_mode  = (mode == 3'd1) ? 3'd0 : 3'd1;
            @(posedge i_clk);
            #1;
            i_start = 1'b0;

            wait_for_flag(1'b1, RENDER_TIMEOUT);
            compare_transfers($sformatf("render %0d mode %0d", r, mode));
        end

        repeat (20) @(posedge i_clk);
        #1;
        if (capture_q.size() != 0) begin
            $display("Error at %0t: %0d extra transfers after last render",
                     $time, capture_q.size());
            error_count++;
        end

        $display("Errors: %0d", error_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/lcd_top_sva.sv */
`timescale 1ns/100ps
`default_nettype none

module lcd_top_sva (
    input wire logic       i_clk,
    input wire logic       i_rst_n,
    input wire logic [7:0] o_lcd_data,
    input wire logic       o_lcd_en,
    input wire logic       o_lcd_rs,
    input wire logic       o_init_finish
);

    logic [3:0] en_len;  // cycles en has been high so far

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            en_len <= 4'd0;
        end else if (o_lcd_en) begin
            en_len <= en_len + 4'd1;
        end else begin
            en_len <= 4'd0;
        end
    end

    pins_stable_while_en: assert property (
        @(posedge i_clk) disable iff (i_rst_n)
        o_lcd_en |=> $stable(o_lcd_rs) && $stable(o_lcd_data)
    ) else $error("rs or data changed while en was high");

    en_pulse_width: assert property (
        @(posedge i_clk) disable iff (i_rst_n)
        $fell(o_lcd_en) |-> en_len == 4'(lcd_pkg::EN_HIGH_CYCLES)
    ) else $error("en pulse was %0d cycles long", en_len);

    init_finish_sticky: assert property (
        @(posedge i_clk) disable iff (i_rst_n)
        o_init_finish |=> o_init_finish
    ) else $error("o_init_finish fell after rising");

endmodule

bind lcd_top lcd_top_sva u_sva (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .o_lcd_data    (o_lcd_data),
    .o_lcd_en      (o_lcd_en),
    .o_lcd_rs      (o_lcd_rs),
    .o_init_finish (o_init_finish)
);

`default_nettype wire

/* src/lcd_top.sv */
`timescale 1ns/100ps
`default_nettype none

module lcd_top (
    input  wire logic       i_clk,
    input  wire logic       i_rst_n,
    input  wire logic       i_start,
    input  wire logic [2:0] i_mode,
    output logic [7:0]      o_lcd_data,
    output logic            o_lcd_en,
    output logic            o_lcd_rs,
    output logic            o_init_finish,
    output logic            o_render_finish
);

    lcd_xfer_if xfer_bus ();

    lcd_pkg::msg_e msg;
    logic [4:0]    pos;
    logic [7:0]    char_code;  // rom output, registered in the controller

    lcd_display_ctrl u_ctrl (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_start         (i_start),
        .i_mode          (i_mode),
        .bus             (xfer_bus.requester),
        .o_msg           (msg),
        .o_pos           (pos),
        .i_char          (char_code),
        .o_init_finish   (o_init_finish),
        .o_render_finish (o_render_finish)
    );

    lcd_message_rom u_rom (
        .i_msg  (msg),
        .i_pos  (pos),
        .o_char (char_code)
    );

    lcd_bus_driver u_driver (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .bus        (xfer_bus.driver),
        .o_lcd_data (o_lcd_data),
        .o_lcd_en   (o_lcd_en),
        .o_lcd_rs   (o_lcd_rs)
    );

endmodule

`default_nettype wire

/* src/lcd_display_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module lcd_display_ctrl (
    input  wire logic       i_clk,
    input  wire logic       i_rst_n,
    input  wire logic       i_start,
    input  wire logic [2:0] i_mode,
    lcd_xfer_if.requester   bus,
    output lcd_pkg::msg_e   o_msg,
    output logic [4:0]      o_pos,
    input  wire logic [7:0] i_char,
    output logic            o_init_finish,
    output logic            o_render_finish
);

    lcd_pkg::ctrl_state_e state_r;
    lcd_pkg::ctrl_state_e state_w;
    lcd_pkg::msg_e        msg_r;
    lcd_pkg::msg_e        msg_w;

    logic       valid_r;
    logic       valid_w;
    logic       rs_r;
    logic       rs_w;
    logic [7:0] data_r;
    logic [7:0] data_w;
    logic [2:0] idx_r;
    logic [2:0] idx_w;
    logic [4:0] pos_r;      // next character to send
    logic [4:0] pos_w;
    logic       init_fin_r;
    logic       init_fin_w;
    logic       render_fin_r;
    logic       render_fin_w;

    always_comb begin
        state_w      = state_r;
        msg_w        = msg_r;
        valid_w      = 1'b0;    // valid is a pulse
        rs_w         = rs_r;
        data_w       = data_r;
        idx_w        = idx_r;
        pos_w        = pos_r;
        init_fin_w   = init_fin_r;
        render_fin_w = render_fin_r;
        case (state_r)
            lcd_pkg::S_BEGIN: begin
                valid_w = 1'b1;
                rs_w    = 1'b0;
                data_w  = lcd_pkg::INIT_SEQ[0];
                idx_w   = 3'd0;
                state_w = lcd_pkg::S_INIT;
            end
            lcd_pkg::S_INIT: begin
                if (bus.done) begin
                    if (idx_r == 3'(lcd_pkg::INIT_COUNT - 1)) begin
                        init_fin_w = 1'b1;
                        state_w    = lcd_pkg::S_IDLE;
                    end else begin
                        idx_w   = idx_r + 3'd1;
                        valid_w = 1'b1;
                        data_w  = lcd_pkg::INIT_SEQ[idx_w];
                    end
                end
            end
            lcd_pkg::S_IDLE: begin
                if (i_start) begin
                    msg_w        = lcd_pkg::msg_e'(i_mode);
                    render_fin_w = 1'b0;
                    pos_w        = 5'd0;
                    valid_w      = 1'b1;
                    rs_w         = 1'b0;
                    data_w       = lcd_pkg::SET_DDRAM;  // line one, address 0
                    state_w      = lcd_pkg::S_SET_ADDRESS;
                end
            end
            lcd_pkg::S_SET_ADDRESS: begin
                if (bus.done) begin
                    valid_w = 1'b1;
                    rs_w    = 1'b1;
                    data_w  = i_char;
                    pos_w   = pos_r + 5'd1;
                    state_w = lcd_pkg::S_WRITE;
                end
            end
            lcd_pkg::S_WRITE: begin
                if (bus.done) begin
                    if (pos_r == 5'd0) begin  // wrapped, all 32 sent
                        render_fin_w = 1'b1;
                        state_w      = lcd_pkg::S_IDLE;
                    end else if (pos_r == 5'(lcd_pkg::LINE_CHARS)) begin
                        valid_w = 1'b1;
                        rs_w    = 1'b0;
                        data_w  = lcd_pkg::SET_DDRAM | lcd_pkg::LINE2_ADDR;
                        state_w = lcd_pkg::S_SET_ADDRESS;
                    end else begin
                        valid_w = 1'b1;
                        rs_w    = 1'b1;
                        data_w  = i_char;
                        pos_w   = pos_r + 5'd1;
                    end
                end
            end
            default: begin
                state_w = lcd_pkg::S_BEGIN;
            end
        endcase
    end

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            state_r      <= lcd_pkg::S_BEGIN;
            msg_r        <= lcd_pkg::MSG_INIT;
            valid_r      <= 1'b0;
            rs_r         <= 1'b0;
            data_r       <= 8'd0;
            idx_r        <= 3'd0;
            pos_r        <= 5'd0;
            init_fin_r   <= 1'b0;
            render_fin_r <= 1'b0;
        end else begin
            state_r      <= state_w;
            msg_r        <= msg_w;
            valid_r      <= valid_w;
            rs_r         <= rs_w;
            data_r       <= data_w;
            idx_r        <= idx_w;
            pos_r        <= pos_w;
            init_fin_r   <= init_fin_w;
            render_fin_r <= render_fin_w;
        end
    end

    assign bus.valid       = valid_r;
    assign bus.rs          = rs_r;
    assign bus.data        = data_r;
    assign o_msg           = msg_r;
    assign o_pos           = pos_r;
    assign o_init_finish   = init_fin_r;
    assign o_render_finish = render_fin_r;

endmodule

`default_nettype wire

/* src/lcd_message_rom.sv */
`timescale 1ns/100ps
`default_nettype none

module lcd_message_rom (
    input  wire lcd_pkg::msg_e  i_msg,
    input  wire logic [4:0]     i_pos,
    output logic [7:0]          o_char
);

    // 32 characters, position 0 in the top byte
    logic [255:0] screen;

    always_comb begin
        case (i_msg)
            lcd_pkg::MSG_INIT: begin
                screen = {"   Initializing ", "                "};
            end
            lcd_pkg::MSG_STOP: begin
                screen = {"   Stop         ", "                "};
            end
            lcd_pkg::MSG_PLAY_PAUSE: begin
                screen = {"   Play Pause   ", "                "};
            end
            lcd_pkg::MSG_REC_PAUSE: begin
                screen = {"   Record Pause ", "                "};
            end
            lcd_pkg::MSG_PLAYING: begin
                screen = {"   Playing      ", "                "};
            end
            default: begin
                // MSG_RECORDING and the unused codes 6, 7
                screen = {"   Recording    ", "                "};
            end
        endcase
    end

    assign o_char = screen[8 * (31 - i_pos) +: 8];

endmodule

`default_nettype wire

/* src/lcd_bus_driver.sv */
`timescale 1ns/100ps
`default_nettype none

module lcd_bus_driver (
    input  wire logic       i_clk,
    input  wire logic       i_rst_n,
    lcd_xfer_if.driver      bus,
    output logic [7:0]      o_lcd_data,
    output logic            o_lcd_en,
    output logic            o_lcd_rs
);

    // 0 is idle, 1..XFER_CYCLES walk setup, en high and hold
    logic [3:0] phase_r;
    logic [3:0] phase_w;
    logic       en_w;
    logic       done_r;

    always_comb begin
        phase_w = phase_r;
        if (bus.valid) begin
            phase_w = 4'd1;
        end else if (phase_r == 4'(lcd_pkg::XFER_CYCLES)) begin
            phase_w = 4'd0;
        end else if (phase_r != 4'd0) begin
            phase_w = phase_r + 4'd1;
        end
    end

    assign en_w = (phase_w > 4'(lcd_pkg::SETUP_CYCLES)) &&
                  (phase_w <= 4'(lcd_pkg::SETUP_CYCLES + lcd_pkg::EN_HIGH_CYCLES));

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            phase_r    <= 4'd0;
            o_lcd_en   <= 1'b0;
            o_lcd_rs   <= 1'b0;
            o_lcd_data <= 8'd0;
            done_r     <= 1'b0;
        end else begin
            phase_r  <= phase_w;
            o_lcd_en <= en_w;  // registered so the pin never glitches
            done_r   <= (phase_w == 4'(lcd_pkg::XFER_CYCLES));
            if (bus.valid) begin
                o_lcd_rs   <= bus.rs;
                o_lcd_data <= bus.data;
            end
        end
    end

    // last hold cycle
    assign bus.done = done_r;

endmodule

`default_nettype wire

/* src/lcd_xfer_if.sv */
`timescale 1ns/100ps
`default_nettype none

// one byte to the LCD, instruction or character
interface lcd_xfer_if;

    logic       valid;  // single-cycle request
    logic       rs;     // 0 instruction, 1 character
    logic [7:0] data;
    logic       done;   // single-cycle completion

    modport requester (
        output valid,
        output rs,
        output data,
        input  done
    );

    modport driver (
        input  valid,
        input  rs,
        input  data,
        output done
    );

endinterface

`default_nettype wire

/* src/lcd_pkg.sv */
`default_nettype none

package lcd_pkg;

    // bus driver phases, in clock cycles
    localparam int SETUP_CYCLES   = 2;  // rs/data stable before en
    localparam int EN_HIGH_CYCLES = 4;
    localparam int HOLD_CYCLES    = 2;
    localparam int XFER_CYCLES    = SETUP_CYCLES + EN_HIGH_CYCLES + HOLD_CYCLES;

    localparam int INIT_COUNT = 5;
    localparam int LINE_CHARS = 16;

    localparam logic [7:0] LINE2_ADDR = 8'h40;

    // HD44780 instruction bytes
    typedef enum logic [7:0] {
        FUNCTION_SET = 8'h38,   // 8-bit bus, two lines, 5x8 font
        DISPLAY_OFF  = 8'h08,
        CLEAR        = 8'h01,
        ENTRY_MODE   = 8'h06,   // increment, no shift
        DISPLAY_ON   = 8'h0C,
        SET_DDRAM    = 8'h80    // low 7 bits carry the address
    } lcd_opcode_e;

    localparam lcd_opcode_e INIT_SEQ [INIT_COUNT] = '{
        FUNCTION_SET,
        DISPLAY_OFF,
        CLEAR,
        ENTRY_MODE,
        DISPLAY_ON
    };

    typedef enum logic [2:0] {
        MSG_INIT       = 3'd0,
        MSG_STOP       = 3'd1,
        MSG_PLAY_PAUSE = 3'd2,
        MSG_REC_PAUSE  = 3'd3,
        MSG_PLAYING    = 3'd4,
        MSG_RECORDING  = 3'd5
    } msg_e;

    typedef enum logic [2:0] {
        S_BEGIN,
        S_INIT,
        S_IDLE,
        S_SET_ADDRESS,
        S_WRITE
    } ctrl_state_e;

endpackage

`default_nettype wire
